/* Bender.yml */
package:
  name: cache

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/cache_pkg.sv
      - verilog/mem_pkg.sv
      - verilog/cache_array.sv
      - verilog/mem_port.sv
      - verilog/cache_ctrl.sv
      - verilog/cache.sv
  - target: simulation
    include_dirs:
      - verilog
    files:
      - bench/cache_assertions.sv
      - bench/cache_checker.sv
      - bench/cache_tb.sv

/* bench/cache_assertions.sv */
`timescale 1ns/10ps
`default_nettype none

`include "cache_consts.svh"

module cache_assertions (
    input  logic                           clk,
    input  logic                           proc_reset,
    input  logic                           proc_read,
    input  logic                           proc_write,
    input  logic                           proc_stall,
    input  logic [`CACHE_WORD_W-1:0]       proc_rdata,
    input  logic                           mem_read,
    input  logic                           mem_write,
    input  logic [`CACHE_BLOCK_ADDR_W-1:0] mem_addr,
    input  logic [`CACHE_BLOCK_W-1:0]      mem_wdata,
    input  logic                           mem_ready
);

    // read by the testbench at the end
    int fail_count = 0;

    a_one_direction: assert property (@(posedge clk) disable iff (proc_reset)
        !(mem_read && mem_write))
        else begin
            $error("mem_read and mem_write high together");
            fail_count++;
        end

    // memory request held until ready
    a_req_stable: assert property (@(posedge clk) disable iff (proc_reset)
        (mem_read || mem_write) && !mem_ready |=>
        $stable(mem_read) && $stable(mem_write) && $stable(mem_addr) && $stable(mem_wdata))
        else begin
            $error("memory request changed before ready");
            fail_count++;
        end

    a_stall_needs_req: assert property (@(posedge clk) disable iff (proc_reset)
        proc_stall |-> (proc_read || proc_write))
        else begin
            $error("proc_stall high without a request");
            fail_count++;
        end

    a_rdata_known: assert property (@(posedge clk) disable iff (proc_reset)
        proc_read && !proc_stall |-> !$isunknown(proc_rdata))
        else begin
            $error("proc_rdata unknown on a completed read");
            fail_count++;
        end

endmodule

bind cache cache_assertions i_assertions (
    .clk        (clk),
    .proc_reset (proc_reset),
    .proc_read  (proc_read),
    .proc_write (proc_write),
    .proc_stall (proc_stall),
    .proc_rdata (proc_rdata),
    .mem_read   (mem_read),
    .mem_write  (mem_write),
    .mem_addr   (mem_addr),
    .mem_wdata  (mem_wdata),
    .mem_ready  (mem_ready)
);

`default_nettype wire

/* bench/cache_checker.sv */
`timescale 1ns/10ps
`default_nettype none

`include "cache_consts.svh"

module cache_checker (
    input  logic                           clk,
    input  logic                           proc_reset,
    input  logic                           proc_read,
    input  logic                           proc_write,
    input  logic [`CACHE_WORD_W-1:0]       proc_rdata,
    input  logic                           proc_stall,
    input  logic                           mem_read,
    input  logic                           mem_write,
    input  logic [`CACHE_BLOCK_ADDR_W-1:0] mem_addr,
    input  logic [`CACHE_BLOCK_W-1:0]      mem_wdata,
    input  logic                           mem_ready,
    input  logic [`CACHE_WORD_W-1:0]       exp_rdata,
    input  logic [`CACHE_BLOCK_W-1:0]      exp_wb_data,
    input  logic [`CACHE_BLOCK_ADDR_W-1:0] exp_wb_addr,
    input  logic                           expect_hit,
    input  logic                           idle_check,
    input  logic                           wb_forbid,
    input  logic                           wb_addr_check,
    output int                             check_count,
    output int                             err_count,
    output int                             wb_count
);

    initial begin
        check_count = 0;
        err_count   = 0;
        wb_count    = 0;
    end

    task automatic compare(input string name, input logic [`CACHE_BLOCK_W-1:0] got,
                           input logic [`CACHE_BLOCK_W-1:0] exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("mismatch %s: expected %0h got %0h", name, exp, got);
        end
    endtask

    task automatic report_failure(input string what);
        err_count++;
        $display("%s", what);
    endtask

    task automatic expect_wb_count(input int n);
        compare("wb_count", wb_count, n);
    endtask

    // outputs settled since the drive at 1 ns after the edge
    always @(negedge clk) begin
        if (!proc_reset) begin
            if (idle_check) begin
                check_count++;
                if (proc_stall || mem_read || mem_write) begin
                    report_failure("cache active without any request");
                end
            end
            if (expect_hit && (proc_read || proc_write) && proc_stall) begin
                report_failure("stall on an access that should hit");
            end
            if (proc_read && !proc_stall) begin
                compare("proc_rdata", proc_rdata, exp_rdata);
            end
            // last cycle of a write-back
            if (mem_write && mem_ready) begin
                wb_count++;
                if (wb_forbid) begin
                    report_failure("write-back on the eviction of a clean line");
                end
                if (wb_addr_check) begin
                    compare("mem_addr", mem_addr, exp_wb_addr);
                end
                compare("mem_wdata", mem_wdata, exp_wb_data);
            end
        end
    end

endmodule

`default_nettype wire

/* bench/cache_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "cache_consts.svh"

module cache_tb;

    localparam int TIMEOUT = 200;
    localparam int WORDS   = 1024;

    logic                           clk;
    logic                           proc_reset;
    logic                           proc_read;
    logic                           proc_write;
    logic [`CACHE_ADDR_W-1:0]       proc_addr;
    logic [`CACHE_WORD_W-1:0]       proc_wdata;
    logic [`CACHE_WORD_W-1:0]       proc_rdata;
    logic                           proc_stall;
    logic                           mem_read;
    logic                           mem_write;
    logic [`CACHE_BLOCK_ADDR_W-1:0] mem_addr;
    logic [`CACHE_BLOCK_W-1:0]      mem_wdata;
    logic [`CACHE_BLOCK_W-1:0]      mem_rdata;
    logic                           mem_ready;
    logic [`CACHE_WORD_W-1:0]       exp_rdata;
    logic [`CACHE_BLOCK_W-1:0]      exp_wb_data;
    logic [`CACHE_BLOCK_ADDR_W-1:0] exp_wb_addr;
    logic                           expect_hit;
    logic                           idle_check;
    logic                           wb_forbid;
    logic                           wb_addr_check;
    int                             check_count;
    int                             err_count;
    int                             wb_count;
    int                             tb_errors;
    int                             test_num;
    int                             last_errs;
    logic [31:0]                    lfsr_q;
    logic [`CACHE_WORD_W-1:0]       mem_words [WORDS];
    logic [`CACHE_WORD_W-1:0]       ref_words [WORDS];

    cache i_dut (
        .clk(clk), .proc_reset(proc_reset),
        .proc_read(proc_read), .proc_write(proc_write), .proc_addr(proc_addr),
        .proc_wdata(proc_wdata), .proc_rdata(proc_rdata), .proc_stall(proc_stall),
        .mem_read(mem_read), .mem_write(mem_write), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_rdata(mem_rdata), .mem_ready(mem_ready)
    );

    cache_checker i_chk (
        .clk(clk), .proc_reset(proc_reset), .proc_read(proc_read),
        .proc_write(proc_write), .proc_rdata(proc_rdata), .proc_stall(proc_stall),
        .mem_read(mem_read), .mem_write(mem_write), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_ready(mem_ready), .exp_rdata(exp_rdata),
        .exp_wb_data(exp_wb_data), .exp_wb_addr(exp_wb_addr), .expect_hit(expect_hit),
        .idle_check(idle_check), .wb_forbid(wb_forbid), .wb_addr_check(wb_addr_check),
        .check_count(check_count), .err_count(err_count), .wb_count(wb_count)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v = {v[30:0], lfsr_q[0]};
        end
    endtask

    // initial memory contents, every address bit counts
    function automatic logic [31:0] pattern(input logic [`CACHE_ADDR_W-1:0] a);
        return {a, 2'b11} ^ {a[13:0], a[29:12]} ^ 32'h6c3a_9e51;
    endfunction

    // reference: word the processor must see at this address
    function automatic logic [31:0] ref_read(input logic [`CACHE_ADDR_W-1:0] a);
        return ref_words[a[9:0]];
    endfunction

    function automatic logic [`CACHE_BLOCK_W-1:0] ref_block(input logic [27:0] b);
        logic [`CACHE_BLOCK_W-1:0] blk;
        for (int k = 0; k < 4; k++) begin
            blk[k*32 +: 32] = ref_words[b[7:0] * 4 + k];
        end
        return blk;
    endfunction

    function automatic logic [`CACHE_BLOCK_W-1:0] mem_block(input logic [27:0] b);
        logic [`CACHE_BLOCK_W-1:0] blk;
        for (int k = 0; k < 4; k++) begin
            blk[k*32 +: 32] = mem_words[b[7:0] * 4 + k];
        end
        return blk;
    endfunction

    function automatic int total_errors();
        return err_count + tb_errors + i_dut.i_assertions.fail_count;
    endfunction

    // block memory, ready after 0 to 3 extra cycles
    always begin : memory_model
        logic [31:0] delay;
        @(negedge clk);
        if (!proc_reset && (mem_read || mem_write)) begin
            if (mem_addr >= WORDS / 4) begin
                tb_errors++;
                $display("memory access outside the modelled range at block %h", mem_addr);
            end
            take_bits(2, delay);
            repeat (delay + 1) @(posedge clk);
            #1;
            mem_ready   = 1'b1;
            mem_rdata   = mem_block(mem_addr);
            exp_wb_data = ref_block(mem_addr);
            @(negedge clk);
            if (mem_write) begin
                for (int k = 0; k < 4; k++) begin
                    mem_words[mem_addr[7:0] * 4 + k] = mem_wdata[k*32 +: 32];
                end
            end
            @(posedge clk);
            #1;
            mem_ready = 1'b0;
        end
    end

    task automatic abort_run(input string what);
        $display("timeout while waiting for %s", what);
        $display("CHECKS FAILED");
        $finish;
    endtask

    // returns 1 ns after the edge that completes the access
    task automatic wait_complete();
        int n;
        n = 0;
        @(negedge clk);
        while (proc_stall) begin
            n++;
            if (n > TIMEOUT) begin
                abort_run("the stall of an access to end");
            end
            @(negedge clk);
        end
        @(posedge clk);
        #1;
    endtask

    task automatic do_access(input logic wr, input logic [`CACHE_ADDR_W-1:0] a,
                             input logic [31:0] d, input logic hit);
        proc_read  = !wr;
        proc_write = wr;
        proc_addr  = a;
        proc_wdata = d;
        exp_rdata  = ref_read(a);
        expect_hit = hit;
        wait_complete();
        if (wr) begin
            ref_words[a[9:0]] = d;
        end
        proc_read  = 1'b0;
        proc_write = 1'b0;
        expect_hit = 1'b0;
    endtask

    task automatic end_test(input string name);
        int errs;
        errs = total_errors();
        test_num++;
        if (errs == last_errs) begin
            $display("test %0d %s: ok", test_num, name);
        end else begin
            $display("test %0d %s: %0d errors", test_num, name, errs - last_errs);
        end
        last_errs = errs;
    endtask

    initial begin
        logic [31:0] r_op;
        logic [31:0] r_addr;
        logic [31:0] r_data;
        clk           = 1'b0;
        proc_reset    = 1'b1;
        proc_read     = 1'b0;
        proc_write    = 1'b0;
        proc_addr     = '0;
        proc_wdata    = '0;
        mem_rdata     = '0;
        mem_ready     = 1'b0;
        exp_rdata     = '0;
        exp_wb_data   = '0;
        exp_wb_addr   = '0;
        expect_hit    = 1'b0;
        idle_check    = 1'b0;
        wb_forbid     = 1'b0;
        wb_addr_check = 1'b0;
        tb_errors     = 0;
        test_num      = 0;
        last_errs     = 0;
        lfsr_q        = 32'h1b23dc87;
        for (int i = 0; i < WORDS; i++) begin
            mem_words[i] = pattern(30'(i));
            ref_words[i] = pattern(30'(i));
        end
        repeat (10) @(posedge clk);
        #1;
        proc_reset = 1'b0;

        idle_check = 1'b1;
        repeat (20) @(posedge clk);
        #1;
        idle_check = 1'b0;
        end_test("idle after reset");

        do_access(1'b0, 30'h013, 32'h0, 1'b0);
        do_access(1'b0, 30'h013, 32'h0, 1'b1);
        end_test("read miss then read hit");

        do_access(1'b1, 30'h021, 32'hdead_beef, 1'b0);
        do_access(1'b0, 30'h021, 32'h0, 1'b1);
        do_access(1'b0, 30'h022, 32'h0, 1'b1);
        end_test("write then read back");

        // index 0 now holds dirty block 8, index 4 clean block 4
        wb_addr_check = 1'b1;
        exp_wb_addr   = 28'h8;
        do_access(1'b0, 30'h041, 32'h0, 1'b0);
        wb_addr_check = 1'b0;
        i_chk.expect_wb_count(1);
        wb_forbid = 1'b1;
        do_access(1'b0, 30'h033, 32'h0, 1'b0);
        wb_forbid = 1'b0;
        i_chk.expect_wb_count(1);
        end_test("dirty and clean eviction");

        // 128 words, so four blocks share each line
        for (int i = 0; i < 300; i++) begin
            take_bits(1, r_op);
            take_bits(7, r_addr);
            take_bits(32, r_data);
            do_access(r_op[0], r_addr[29:0], r_data, 1'b0);
        end
        end_test("random accesses");

        $display("tests %0d, checks %0d, write-backs %0d, errors %0d",
                 test_num, check_count, wb_count, total_errors());
        if (total_errors() == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* cache.f */
+incdir+verilog
verilog/cache_pkg.sv
verilog/mem_pkg.sv
verilog/cache_array.sv
verilog/mem_port.sv
verilog/cache_ctrl.sv
verilog/cache.sv
bench/cache_assertions.sv
bench/cache_checker.sv
bench/cache_tb.sv

/* verilog/cache.sv */
`timescale 1ns/10ps
`default_nettype none

`include "cache_consts.svh"

module cache (
    input  logic                           clk,
    input  logic                           proc_reset,
    input  logic                           proc_read,
    input  logic                           proc_write,
    input  logic [`CACHE_ADDR_W-1:0]       proc_addr,
    input  logic [`CACHE_WORD_W-1:0]       proc_wdata,
    output logic [`CACHE_WORD_W-1:0]       proc_rdata,
    output logic                           proc_stall,
    output logic                           mem_read,
    output logic                           mem_write,
    output logic [`CACHE_BLOCK_ADDR_W-1:0] mem_addr,
    output logic [`CACHE_BLOCK_W-1:0]      mem_wdata,
    input  logic [`CACHE_BLOCK_W-1:0]      mem_rdata,
    input  logic                           mem_ready
);

    cache_pkg::proc_req_t      proc_req;
    cache_pkg::line_t          line;
    cache_pkg::line_op_e       op;
    mem_pkg::mem_req_t         mem_req;
    mem_pkg::mem_rsp_t         mem_rsp;
    mem_pkg::mem_job_t         job;
    logic [`CACHE_WORD_W-1:0]  rword;
    logic [`CACHE_BLOCK_W-1:0] refill_data;
    logic                      start;
    logic                      done;

    assign proc_req = '{read: proc_read, write: proc_write, addr: proc_addr, wdata: proc_wdata};
    assign mem_rsp  = '{ready: mem_ready, rdata: mem_rdata};

    assign mem_read  = mem_req.read;
    assign mem_write = mem_req.write;
    assign mem_addr  = mem_req.addr;
    assign mem_wdata = mem_req.wdata;

    cache_array i_array (
        .clk        (clk),
        .proc_reset (proc_reset),
        .index      (proc_addr[`CACHE_OFFSET_W +: `CACHE_INDEX_W]),
        .offset     (proc_addr[`CACHE_OFFSET_W-1:0]),
        .op         (op),
        .tag        (proc_addr[`CACHE_ADDR_W-1 -: `CACHE_TAG_W]),
        .wdata      (proc_wdata),
        .fill_data  (refill_data),
        .line       (line),
        .rword      (rword)
    );

    cache_ctrl i_ctrl (
        .clk         (clk),
        .proc_reset  (proc_reset),
        .req         (proc_req),
        .line        (line),
        .rword       (rword),
        .done        (done),
        .refill_data (refill_data),
        .stall       (proc_stall),
        .rdata       (proc_rdata),
        .op          (op),
        .start       (start),
        .job         (job)
    );

    mem_port i_mem_port (
        .clk         (clk),
        .proc_reset  (proc_reset),
        .start       (start),
        .job         (job),
        .rsp         (mem_rsp),
        .req         (mem_req),
        .done        (done),
        .refill_data (refill_data)
    );

endmodule

`default_nettype wire

/* verilog/cache_array.sv */
`timescale 1ns/10ps
`default_nettype none

`include "cache_consts.svh"

module cache_array (
    input  logic                        clk,
    input  logic                        proc_reset,
    input  logic [`CACHE_INDEX_W-1:0]   index,
    input  logic [`CACHE_OFFSET_W-1:0]  offset,
    input  cache_pkg::line_op_e         op,
    input  logic [`CACHE_TAG_W-1:0]     tag,
    input  logic [`CACHE_WORD_W-1:0]    wdata,
    input  logic [`CACHE_BLOCK_W-1:0]   fill_data,
    output cache_pkg::line_t            line,
    output logic [`CACHE_WORD_W-1:0]    rword
);

    logic [`CACHE_LINES-1:0]   valid_q;
    logic [`CACHE_LINES-1:0]   dirty_q;
    logic [`CACHE_TAG_W-1:0]   tag_q  [`CACHE_LINES];
    logic [`CACHE_BLOCK_W-1:0] data_q [`CACHE_LINES];
    logic [`CACHE_BLOCK_W-1:0] cur_data;
    logic [`CACHE_BLOCK_W-1:0] new_data;

    // replace one word of a block
    function automatic logic [`CACHE_BLOCK_W-1:0] put_word(
        input logic [`CACHE_BLOCK_W-1:0]  blk,
        input logic [`CACHE_OFFSET_W-1:0] off,
        input logic [`CACHE_WORD_W-1:0]   w
    );
        logic [`CACHE_BLOCK_W-1:0] res;
        res = blk;
        res[off*`CACHE_WORD_W +: `CACHE_WORD_W] = w;
        return res;
    endfunction

    assign cur_data = data_q[index];
    assign rword    = cur_data[offset*`CACHE_WORD_W +: `CACHE_WORD_W];
    assign line     = '{valid: valid_q[index], dirty: dirty_q[index],
                        tag: tag_q[index], data: cur_data};

    always_comb begin
        case (op)
            cache_pkg::op_write_word: new_data = put_word(cur_data, offset, wdata);
            cache_pkg::op_fill_clean: new_data = fill_data;
            cache_pkg::op_fill_merge: new_data = put_word(fill_data, offset, wdata);
            default:                  new_data = cur_data;
        endcase
    end

    always_ff @(posedge clk or posedge proc_reset) begin
        if (proc_reset) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            case (op)
                cache_pkg::op_write_word: begin
                    dirty_q[index] <= 1'b1;
                end
                cache_pkg::op_fill_clean: begin
                    valid_q[index] <= 1'b1;
                    dirty_q[index] <= 1'b0;
                end
                cache_pkg::op_fill_merge: begin
                    valid_q[index] <= 1'b1;
                    dirty_q[index] <= 1'b1;
                end
                default: begin
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (op != cache_pkg::op_none) begin
            data_q[index] <= new_data;
            // tag only changes on a fill
            if (op != cache_pkg::op_write_word) begin
                tag_q[index] <= tag;
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/cache_consts.svh */
`ifndef CACHE_CONSTS_SVH
`define CACHE_CONSTS_SVH

// word and processor address
`define CACHE_WORD_W       32
`define CACHE_ADDR_W       30

// address split: tag | index | word offset
`define CACHE_TAG_W        25
`define CACHE_INDEX_W      3
`define CACHE_OFFSET_W     2

// direct mapped, 8 lines
`define CACHE_LINES        8

// one block is 4 words
`define CACHE_BLOCK_W      128
`define CACHE_BLOCK_ADDR_W 28

`endif

/* verilog/cache_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

`include "cache_consts.svh"

module cache_ctrl (
    input  logic                      clk,
    input  logic                      proc_reset,
    input  cache_pkg::proc_req_t      req,
    input  cache_pkg::line_t          line,
    input  logic [`CACHE_WORD_W-1:0]  rword,
    input  logic                      done,
    input  logic [`CACHE_BLOCK_W-1:0] refill_data,
    output logic                      stall,
    output logic [`CACHE_WORD_W-1:0]  rdata,
    output cache_pkg::line_op_e       op,
    output logic                      start,
    output mem_pkg::mem_job_t         job
);

    cache_pkg::ctrl_state_e         state_q;
    cache_pkg::ctrl_state_e         state_d;
    logic [`CACHE_TAG_W-1:0]        req_tag;
    logic [`CACHE_INDEX_W-1:0]      req_index;
    logic [`CACHE_OFFSET_W-1:0]     req_offset;
    logic [`CACHE_BLOCK_ADDR_W-1:0] victim_addr;
    logic                           access;
    logic                           hit;

    assign req_tag    = req.addr[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];
    assign req_index  = req.addr[`CACHE_OFFSET_W +: `CACHE_INDEX_W];
    assign req_offset = req.addr[`CACHE_OFFSET_W-1:0];

    assign access = req.read | req.write;
    assign hit    = line.valid && (line.tag == req_tag);

    // victim sits at the same index, under its own tag
    assign victim_addr = {line.tag, req_index};

    assign job = '{
        writeback:   line.valid & line.dirty,
        victim_addr: victim_addr,
        victim_data: line.data,
        refill_addr: req.addr[`CACHE_ADDR_W-1:`CACHE_OFFSET_W]
    };

    // during the fill the array still shows the old line
    assign rdata = (state_q == cache_pkg::st_fill) ?
                   refill_data[req_offset*`CACHE_WORD_W +: `CACHE_WORD_W] : rword;

    always_comb begin
        state_d = state_q;
        stall   = 1'b0;
        start   = 1'b0;
        op      = cache_pkg::op_none;
        case (state_q)
            cache_pkg::st_lookup: begin
                if (access) begin
                    if (hit) begin
                        if (req.write) begin
                            op = cache_pkg::op_write_word;
                        end
                    end else begin
                        stall   = 1'b1;
                        start   = 1'b1;
                        state_d = cache_pkg::st_wait_mem;
                    end
                end
            end
            cache_pkg::st_wait_mem: begin
                stall = access;
                if (done) begin
                    state_d = cache_pkg::st_fill;
                end
            end
            cache_pkg::st_fill: begin
                // access repeats as a hit next cycle
                stall   = access;
                op      = req.write ? cache_pkg::op_fill_merge : cache_pkg::op_fill_clean;
                state_d = cache_pkg::st_lookup;
            end
            default: begin
                state_d = cache_pkg::st_lookup;
            end
        endcase
    end

    always_ff @(posedge clk or posedge proc_reset) begin
        if (proc_reset) begin
            state_q <= cache_pkg::st_lookup;
        end else begin
            state_q <= state_d;
        end
    end

endmodule

`default_nettype wire

/* verilog/cache_pkg.sv */
`default_nettype none

`include "cache_consts.svh"

package cache_pkg;

    // processor request as held by the core
    typedef struct packed {
        logic                     read;
        logic                     write;
        logic [`CACHE_ADDR_W-1:0] addr;
        logic [`CACHE_WORD_W-1:0] wdata;
    } proc_req_t;

    // one cache line
    typedef struct packed {
        logic                      valid;
        logic                      dirty;
        logic [`CACHE_TAG_W-1:0]   tag;
        logic [`CACHE_BLOCK_W-1:0] data;
    } line_t;

    // what the array does with the indexed line at the next edge
    typedef enum logic [1:0] {
        op_none,
        op_write_word,
        op_fill_clean,
        op_fill_merge
    } line_op_e;

    typedef enum logic [1:0] {
        st_lookup,
        st_wait_mem,
        st_fill
    } ctrl_state_e;

endpackage

`default_nettype wire

/* verilog/mem_pkg.sv */
`default_nettype none

`include "cache_consts.svh"

package mem_pkg;

    typedef struct packed {
        logic                           read;
        logic                           write;
        logic [`CACHE_BLOCK_ADDR_W-1:0] addr;
        logic [`CACHE_BLOCK_W-1:0]      wdata;
    } mem_req_t;

    typedef struct packed {
        logic                      ready;
        logic [`CACHE_BLOCK_W-1:0] rdata;
    } mem_rsp_t;

    // handed over with start; write-back runs before refill
    typedef struct packed {
        logic                           writeback;
        logic [`CACHE_BLOCK_ADDR_W-1:0] victim_addr;
        logic [`CACHE_BLOCK_W-1:0]      victim_data;
        logic [`CACHE_BLOCK_ADDR_W-1:0] refill_addr;
    } mem_job_t;

    typedef enum logic [1:0] {
        ms_idle,
        ms_writeback,
        ms_refill
    } mem_state_e;

endpackage

`default_nettype wire

/* verilog/mem_port.sv */
`timescale 1ns/10ps
`default_nettype none

`include "cache_consts.svh"

module mem_port (
    input  logic                      clk,
    input  logic                      proc_reset,
    input  logic                      start,
    input  mem_pkg::mem_job_t         job,
    input  mem_pkg::mem_rsp_t         rsp,
    output mem_pkg::mem_req_t         req,
    output logic                      done,
    output logic [`CACHE_BLOCK_W-1:0] refill_data
);

    mem_pkg::mem_state_e            state_q;
    logic                           read_q;
    logic                           write_q;
    logic                           done_q;
    logic [`CACHE_BLOCK_ADDR_W-1:0] addr_q;
    logic [`CACHE_BLOCK_ADDR_W-1:0] refill_addr_q;
    logic [`CACHE_BLOCK_W-1:0]      wdata_q;
    logic [`CACHE_BLOCK_W-1:0]      refill_q;
    logic                           take_job;
    logic                           wb_end;
    logic                           refill_end;

    assign take_job   = (state_q == mem_pkg::ms_idle) && start;
    assign wb_end     = (state_q == mem_pkg::ms_writeback) && rsp.ready;
    assign refill_end = (state_q == mem_pkg::ms_refill) && rsp.ready;

    assign req         = '{read: read_q, write: write_q, addr: addr_q, wdata: wdata_q};
    assign done        = done_q;
    assign refill_data = refill_q;

    always_ff @(posedge clk or posedge proc_reset) begin
        if (proc_reset) begin
            state_q <= mem_pkg::ms_idle;
            read_q  <= 1'b0;
            write_q <= 1'b0;
            done_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (take_job) begin
                if (job.writeback) begin
                    write_q <= 1'b1;
                    state_q <= mem_pkg::ms_writeback;
                end else begin
                    read_q  <= 1'b1;
                    state_q <= mem_pkg::ms_refill;
                end
            end else if (wb_end) begin
                // refill goes out right behind the write-back
                write_q <= 1'b0;
                read_q  <= 1'b1;
                state_q <= mem_pkg::ms_refill;
            end else if (refill_end) begin
                read_q  <= 1'b0;
                done_q  <= 1'b1;
                state_q <= mem_pkg::ms_idle;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take_job) begin
            addr_q        <= job.writeback ? job.victim_addr : job.refill_addr;
            wdata_q       <= job.victim_data;
            refill_addr_q <= job.refill_addr;
        end else if (wb_end) begin
            addr_q <= refill_addr_q;
        end else if (refill_end) begin
            refill_q <= rsp.rdata;
        end
    end

endmodule

`default_nettype wire
